/* source/smArithPkg.sv */
package smArithPkg;

	// sign-magnitude word with the sign in bit 15
	typedef struct packed {
		logic        sign;
		logic [14:0] mag;
	} smWord_t;

	typedef enum logic [1:0] {
		OP_MUL,
		OP_DIV,
		OP_REM
	} arithOp_t;

	typedef struct packed {
		arithOp_t op;
		smWord_t  a;
		smWord_t  b;
	} arithReq_t;

	typedef struct packed {
		smWord_t value;
		logic    divZero;
	} arithRsp_t;

	// engine states shared by multiply and divide
	typedef enum logic [3:0] {
		IDLE,
		SET,
		CHECK,
		STEP,
		FIN
	} engState_t;

	typedef enum logic [1:0] {
		WAIT,
		RUN,
		HOLD,
		RELEASE
	} ctlState_t;

endpackage

/* source/adder15.sv */
module adder15 (
	input  logic [14:0] in1,
	input  logic [14:0] in2,
	input  logic        sub,
	output logic [14:0] sum,
	output logic        cOut
);

	logic [14:0] operand;
	logic [15:0] total;

	// two's complement by invert and add one
	assign operand = sub ? ~in2 : in2;
	assign total = {1'b0, in1} + {1'b0, operand} + {15'b0, sub};

	assign sum = total[14:0];
	// carry set on subtract means in1 >= in2
	assign cOut = total[15];

endmodule

/* source/multiply.sv */
module multiply import smArithPkg::*; (
	input  logic    clk,
	input  logic    nRST,
	input  logic    start,
	input  smWord_t a,
	input  smWord_t b,
	output smWord_t product,
	output logic    finish
);

	engState_t state, nextState;

	logic [14:0] aMag, nextAMag;
	logic [14:0] bMag, nextBMag;
	logic        sign, nextSign;

	// running sum and step count
	logic [14:0] acc, nextAcc;
	logic [14:0] count, nextCount;

	logic [14:0] accSum;
	logic [14:0] countSum;
	logic        countDone;

	smWord_t nextProduct;
	logic    nextFinish;

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			aMag <= '0;
			bMag <= '0;
			sign <= 1'b0;
			acc <= '0;
			count <= '0;
			product <= '0;
			finish <= 1'b0;
		end else begin
			state <= nextState;
			aMag <= nextAMag;
			bMag <= nextBMag;
			sign <= nextSign;
			acc <= nextAcc;
			count <= nextCount;
			product <= nextProduct;
			finish <= nextFinish;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (start) begin
					nextState = SET;
				end
			end
			SET: begin
				// zero multiplier needs no loop
				if (b.mag == 15'b0) begin
					nextState = FIN;
				end else begin
					nextState = CHECK;
				end
			end
			CHECK: begin
				if (countDone) begin
					nextState = FIN;
				end else begin
					nextState = STEP;
				end
			end
			STEP: begin
				nextState = CHECK;
			end
			FIN: begin
				if (!start) begin
					nextState = IDLE;
				end
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	// accumulator wraps mod 2^15
	adder15 accAdd (
		.in1(acc),
		.in2(aMag),
		.sub(1'b0),
		.sum(accSum),
		.cOut()
	);

	adder15 stepCount (
		.in1(count),
		.in2(15'd1),
		.sub(1'b0),
		.sum(countSum),
		.cOut()
	);

	// count >= |b| ends the loop
	adder15 doneCmp (
		.in1(count),
		.in2(bMag),
		.sub(1'b1),
		.sum(),
		.cOut(countDone)
	);

	always_comb begin
		nextAMag = aMag;
		nextBMag = bMag;
		nextSign = sign;
		nextAcc = acc;
		nextCount = count;
		nextProduct = product;
		nextFinish = (state == FIN);

		case (state)
			SET: begin
				nextAMag = a.mag;
				nextBMag = b.mag;
				nextSign = a.sign ^ b.sign;
				nextAcc = '0;
				nextCount = '0;
			end
			STEP: begin
				nextAcc = accSum;
				nextCount = countSum;
			end
			FIN: begin
				nextProduct.sign = sign;
				nextProduct.mag = acc;
			end
		endcase
	end

endmodule

/* source/divide.sv */
module divide import smArithPkg::*; (
	input  logic    clk,
	input  logic    nRST,
	input  logic    start,
	input  smWord_t a,
	input  smWord_t b,
	output smWord_t quotient,
	output smWord_t remainder,
	output logic    divZero,
	output logic    finish
);

	engState_t state, nextState;

	logic [14:0] remMag, nextRemMag;
	logic [14:0] divisor, nextDivisor;
	logic [14:0] quot, nextQuot;
	logic        qSign, nextQSign;
	logic        rSign, nextRSign;
	logic        zero, nextZero;

	logic [14:0] diff;
	logic        fits;
	logic [14:0] quotInc;

	smWord_t nextQuotient;
	smWord_t nextRemainder;
	logic    nextDivZero;
	logic    nextFinish;

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			remMag <= '0;
			divisor <= '0;
			quot <= '0;
			qSign <= 1'b0;
			rSign <= 1'b0;
			zero <= 1'b0;
			quotient <= '0;
			remainder <= '0;
			divZero <= 1'b0;
			finish <= 1'b0;
		end else begin
			state <= nextState;
			remMag <= nextRemMag;
			divisor <= nextDivisor;
			quot <= nextQuot;
			qSign <= nextQSign;
			rSign <= nextRSign;
			zero <= nextZero;
			quotient <= nextQuotient;
			remainder <= nextRemainder;
			divZero <= nextDivZero;
			finish <= nextFinish;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (start) begin
					nextState = SET;
				end
			end
			SET: begin
				if (b.mag == 15'b0) begin
					nextState = FIN;
				end else begin
					nextState = CHECK;
				end
			end
			CHECK: begin
				if (fits) begin
					nextState = STEP;
				end else begin
					nextState = FIN;
				end
			end
			STEP: begin
				nextState = CHECK;
			end
			FIN: begin
				if (!start) begin
					nextState = IDLE;
				end
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	// carry out says the divisor still fits
	adder15 subStep (
		.in1(remMag),
		.in2(divisor),
		.sub(1'b1),
		.sum(diff),
		.cOut(fits)
	);

	adder15 quotCount (
		.in1(quot),
		.in2(15'd1),
		.sub(1'b0),
		.sum(quotInc),
		.cOut()
	);

	always_comb begin
		nextRemMag = remMag;
		nextDivisor = divisor;
		nextQuot = quot;
		nextQSign = qSign;
		nextRSign = rSign;
		nextZero = zero;
		nextQuotient = quotient;
		nextRemainder = remainder;
		nextDivZero = divZero;
		nextFinish = (state == FIN);

		case (state)
			SET: begin
				nextDivisor = b.mag;
				nextQuot = '0;
				nextQSign = a.sign ^ b.sign;
				nextRSign = a.sign;
				nextZero = (b.mag == 15'b0);
				// divide by zero reports zero magnitudes
				nextRemMag = (b.mag == 15'b0) ? 15'b0 : a.mag;
			end
			STEP: begin
				nextRemMag = diff;
				nextQuot = quotInc;
			end
			FIN: begin
				nextQuotient.sign = qSign;
				nextQuotient.mag = quot;
				nextRemainder.sign = rSign;
				nextRemainder.mag = remMag;
				nextDivZero = zero;
			end
		endcase
	end

endmodule

/* source/arithControl.sv */
module arithControl import smArithPkg::*; (
	input  logic      clk,
	input  logic      nRST,
	input  logic      req,
	input  arithReq_t reqData,
	output logic      ack,
	output arithRsp_t rsp,
	output smWord_t   a,
	output smWord_t   b,
	output logic      mulStart,
	output logic      divStart,
	input  logic      mulFinish,
	input  logic      divFinish,
	input  smWord_t   product,
	input  smWord_t   quotient,
	input  smWord_t   remainder,
	input  logic      divZero
);

	ctlState_t state;
	arithReq_t reqReg;
	logic      useMul;
	logic      engFinish;
	arithRsp_t result;

	assign useMul = (reqReg.op == OP_MUL);
	// finish of the engine in use
	assign engFinish = useMul ? mulFinish : divFinish;

	assign a = reqReg.a;
	assign b = reqReg.b;

	always_comb begin
		case (reqReg.op)
			OP_MUL: result.value = product;
			OP_REM: result.value = remainder;
			default: result.value = quotient;
		endcase
		result.divZero = useMul ? 1'b0 : divZero;
	end

	always_ff @(posedge clk, negedge nRST) begin
		if (!nRST) begin
			state <= WAIT;
			reqReg <= '0;
			rsp <= '0;
			ack <= 1'b0;
			mulStart <= 1'b0;
			divStart <= 1'b0;
		end else begin
			case (state)
				WAIT: begin
					if (req) begin
						reqReg <= reqData;
						mulStart <= (reqData.op == OP_MUL);
						divStart <= (reqData.op != OP_MUL);
						state <= RUN;
					end
				end
				RUN: begin
					// drop start and publish result together
					if (engFinish) begin
						mulStart <= 1'b0;
						divStart <= 1'b0;
						rsp <= result;
						ack <= 1'b1;
						state <= HOLD;
					end
				end
				HOLD: begin
					if (!req) begin
						state <= RELEASE;
					end
				end
				RELEASE: begin
					// wait for the engine to go idle
					if (!engFinish) begin
						ack <= 1'b0;
						state <= WAIT;
					end
				end
				default: begin
					state <= WAIT;
				end
			endcase
		end
	end

endmodule

/* source/smArithUnit.sv */
module smArithUnit import smArithPkg::*; (
	input  logic      clk,
	input  logic      nRST,
	input  logic      req,
	input  arithReq_t reqData,
	output logic      ack,
	output arithRsp_t rsp
);

	smWord_t a;
	smWord_t b;
	logic    mulStart;
	logic    divStart;
	logic    mulFinish;
	logic    divFinish;
	smWord_t product;
	smWord_t quotient;
	smWord_t remainder;
	logic    divZero;

	arithControl ctrl (
		.clk(clk),
		.nRST(nRST),
		.req(req),
		.reqData(reqData),
		.ack(ack),
		.rsp(rsp),
		.a(a),
		.b(b),
		.mulStart(mulStart),
		.divStart(divStart),
		.mulFinish(mulFinish),
		.divFinish(divFinish),
		.product(product),
		.quotient(quotient),
		.remainder(remainder),
		.divZero(divZero)
	);

	multiply mulEngine (
		.clk(clk),
		.nRST(nRST),
		.start(mulStart),
		.a(a),
		.b(b),
		.product(product),
		.finish(mulFinish)
	);

	divide divEngine (
		.clk(clk),
		.nRST(nRST),
		.start(divStart),
		.a(a),
		.b(b),
		.quotient(quotient),
		.remainder(remainder),
		.divZero(divZero),
		.finish(divFinish)
	);

endmodule

/* verif/smArith_checker.sv */
module smArith_checker import smArithPkg::*; (
	input logic      clk,
	input logic      nRST,
	input logic      req,
	input logic      ack,
	input arithRsp_t rsp,
	input logic      mulStart,
	input logic      divStart
);

	// failed assertion count
	int assertFails = 0;

	// ack only answers a live request
	ackNeedsReq: assert property (@(posedge clk) disable iff (!nRST)
		$rose(ack) |-> $past(req))
		else begin
			assertFails++;
			$error("ack rose without a pending req");
		end

	rspStable: assert property (@(posedge clk) disable iff (!nRST)
		(ack && $past(ack)) |-> $stable(rsp))
		else begin
			assertFails++;
			$error("rsp changed while ack was high");
		end

	oneStart: assert property (@(posedge clk) disable iff (!nRST)
		!(mulStart && divStart))
		else begin
			assertFails++;
			$error("both engine starts high");
		end

	// req drops before ack in four-phase
	ackFallsLate: assert property (@(posedge clk) disable iff (!nRST)
		$fell(ack) |-> !$past(req))
		else begin
			assertFails++;
			$error("ack fell while req was still high");
		end

endmodule

bind arithControl smArith_checker handshakeChk (
	.clk(clk),
	.nRST(nRST),
	.req(req),
	.ack(ack),
	.rsp(rsp),
	.mulStart(mulStart),
	.divStart(divStart)
);

/* verif/smArithTb.sv */
module smArithTb import smArithPkg::*; ();

	// ops issued by all tests together
	localparam int NUM_OPS = 25;
	localparam int CYCLE_LIMIT = NUM_OPS * (2 * 255 + 20);

	logic      clk;
	logic      nRST;
	logic      req;
	logic      ack;
	arithReq_t reqData;
	arithRsp_t rsp;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycles = 0;

	smArithUnit DUT (
		.clk(clk),
		.nRST(nRST),
		.req(req),
		.reqData(reqData),
		.ack(ack),
		.rsp(rsp)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("handshake stalled, no completion within %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic checkWord(input string name, input smWord_t got, input smWord_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got sign %b mag %0d, expected sign %b mag %0d",
				$time, name, got.sign, got.mag, exp.sign, exp.mag);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
		end
	endtask

	function automatic smWord_t makeWord(input logic sign, input int mag);
		smWord_t w;
		w.sign = sign;
		w.mag = mag[14:0];
		return w;
	endfunction

	// expected response straight from the arithmetic rules
	function automatic arithRsp_t ruleResult(input arithReq_t r);
		arithRsp_t e;
		int prod;
		e.divZero = 1'b0;
		case (r.op)
			OP_MUL: begin
				e.value.sign = r.a.sign ^ r.b.sign;
				prod = int'(r.a.mag) * int'(r.b.mag);
				e.value.mag = prod[14:0];
			end
			OP_DIV: begin
				e.value.sign = r.a.sign ^ r.b.sign;
				e.divZero = (r.b.mag == 15'd0);
				e.value.mag = e.divZero ? 15'd0 : r.a.mag / r.b.mag;
			end
			default: begin
				e.value.sign = r.a.sign;
				e.divZero = (r.b.mag == 15'd0);
				e.value.mag = e.divZero ? 15'd0 : r.a.mag % r.b.mag;
			end
		endcase
		return e;
	endfunction

	// full four-phase cycle with req optionally held past ack
	task automatic handshake(input arithReq_t r, input int holdCycles, output arithRsp_t got);
		@(negedge clk);
		reqData = r;
		req = 1'b1;
		@(negedge clk);
		while (!ack) @(negedge clk);
		got = rsp;
		repeat (holdCycles) begin
			@(negedge clk);
			checkFlag("ack", ack, 1'b1);
			checkWord("rsp.value", rsp.value, got.value);
			checkFlag("rsp.divZero", rsp.divZero, got.divZero);
		end
		req = 1'b0;
		@(negedge clk);
		while (ack) @(negedge clk);
	endtask

	task automatic checkOp(input arithOp_t op, input smWord_t a, input smWord_t b,
		input int holdCycles);
		arithReq_t r;
		arithRsp_t got;
		arithRsp_t exp;
		r.op = op;
		r.a = a;
		r.b = b;
		exp = ruleResult(r);
		handshake(r, holdCycles, got);
		checkWord({op.name(), " value"}, got.value, exp.value);
		checkFlag({op.name(), " divZero"}, got.divZero, exp.divZero);
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		tests++;
		if (errors == errsBefore) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errsBefore);
		end
	endtask

	task automatic mulSigns();
		int errsBefore;
		errsBefore = errors;
		for (int s = 0; s < 4; s++) begin
			checkOp(OP_MUL, makeWord(s[1], 23), makeWord(s[0], 11), 0);
		end
		reportTest("mulSigns", errsBefore);
	endtask

	task automatic mulWrap();
		int errsBefore;
		errsBefore = errors;
		// products past 15 bits wrap
		checkOp(OP_MUL, makeWord(0, 1000), makeWord(0, 200), 0);
		checkOp(OP_MUL, makeWord(1, 32767), makeWord(0, 3), 0);
		checkOp(OP_MUL, makeWord(1, 77), makeWord(0, 0), 0);
		checkOp(OP_MUL, makeWord(0, 0), makeWord(1, 5), 0);
		reportTest("mulWrap", errsBefore);
	endtask

	task automatic divRandom();
		int errsBefore;
		int bMag;
		int q;
		int r;
		smWord_t a;
		smWord_t b;
		errsBefore = errors;
		repeat (6) begin
			// divisor up to 127 keeps q*b+r inside 15 bits
			bMag = $urandom_range(127, 1);
			q = $urandom_range(255, 0);
			r = $urandom_range(bMag - 1, 0);
			a = makeWord($urandom_range(1, 0), q * bMag + r);
			b = makeWord($urandom_range(1, 0), bMag);
			checkOp(OP_DIV, a, b, 0);
			checkOp(OP_REM, a, b, 0);
		end
		reportTest("divRandom", errsBefore);
	endtask

	task automatic divByZero();
		int errsBefore;
		errsBefore = errors;
		checkOp(OP_DIV, makeWord(1, 500), makeWord(0, 0), 0);
		checkOp(OP_REM, makeWord(1, 500), makeWord(1, 0), 0);
		// stale divZero must not leak into a multiply
		checkOp(OP_MUL, makeWord(0, 6), makeWord(0, 7), 0);
		reportTest("divByZero", errsBefore);
	endtask

	task automatic backPressure();
		int errsBefore;
		errsBefore = errors;
		checkOp(OP_REM, makeWord(1, 1234), makeWord(0, 100), 6);
		checkOp(OP_DIV, makeWord(0, 9999), makeWord(1, 37), 0);
		reportTest("backPressure", errsBefore);
	endtask

	initial begin
		int assertFails;
		void'($urandom(32'h7b8e_d0ee));
		nRST = 1'b0;
		req = 1'b0;
		reqData = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		nRST = 1'b1;

		mulSigns();
		mulWrap();
		divRandom();
		divByZero();
		backPressure();

		assertFails = DUT.ctrl.handshakeChk.assertFails;
		errors = errors + assertFails;
		$display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
			tests, checks, assertFails, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
source/smArithPkg.sv
source/adder15.sv
source/multiply.sv
source/divide.sv
source/arithControl.sv
source/smArithUnit.sv
verif/smArith_checker.sv
verif/smArithTb.sv

/* Bender.yml */
package:
  name: sm_arith

sources:
  - source/smArithPkg.sv
  - source/adder15.sv
  - source/multiply.sv
  - source/divide.sv
  - source/arithControl.sv
  - source/smArithUnit.sv

  - target: test
    files:
      - verif/smArith_checker.sv
      - verif/smArithTb.sv
